/* source/gfx_pkg.sv */
`default_nettype none

package gfx;

	// *******************************************************************
	// Data path word and its byte lanes.
	// *******************************************************************

	typedef logic [31:0] word;

	localparam int BYTES_PER_WORD = $bits(word) / 8;
	localparam int SUBWORD_BITS = $clog2(BYTES_PER_WORD); // Byte offset inside a word.

	// One bit per byte lane.
	typedef logic [BYTES_PER_WORD - 1:0] word_strb;

	// *******************************************************************
	// Scheduler memory map.
	// *******************************************************************

	// Scratchpad depth in words, window starts at address zero.
	localparam int SCHED_BRAM_WORDS_DEFAULT = 1024;

endpackage

`default_nettype wire

/* source/sched_scratchpad.sv */
`default_nettype none

module sched_scratchpad #(
	parameter int SCRATCH_WORDS = gfx::SCHED_BRAM_WORDS_DEFAULT
) (
	input  wire logic                               clk,

	input  wire logic [$clog2(SCRATCH_WORDS) - 1:0] addr,
	input  wire logic                               we,
	input  wire gfx::word_strb                      wstrb,
	input  wire gfx::word                           wdata,
	output gfx::word                                rdata
);

	import gfx::*;

	localparam int LANE_BITS = $bits(word) / BYTES_PER_WORD;

	genvar i;
	generate
		for (i = 0; i < BYTES_PER_WORD; i++) begin : byte_lanes
			logic [LANE_BITS - 1:0] lane_mem [SCRATCH_WORDS];
			logic [LANE_BITS - 1:0] lane_q;

			// Old contents come out on a write to the same word.
			always_ff @(posedge clk) begin
				lane_q <= lane_mem[addr];
				if (we && wstrb[i])
					lane_mem[addr] <= wdata[LANE_BITS * i +: LANE_BITS];
			end

			assign rdata[LANE_BITS * i +: LANE_BITS] = lane_q;
		end
	endgenerate

endmodule

`default_nettype wire

/* source/sched_axil_master.sv */
`default_nettype none

module sched_axil_master (
	input  wire logic          clk,
	input  wire logic          rst_n,

	// Core side, one request at a time.
	input  wire logic          req_valid,
	input  wire gfx::word      req_addr,
	input  wire gfx::word      req_wdata,
	input  wire gfx::word_strb req_wstrb,
	output logic               req_ready,
	output gfx::word           req_rdata,

	// AXI-lite side.
	output logic               awvalid,
	input  wire logic          awready,
	output gfx::word           awaddr,

	output logic               wvalid,
	input  wire logic          wready,
	output gfx::word           wdata,
	output gfx::word_strb      wstrb,

	input  wire logic          bvalid,
	output logic               bready,

	output logic               arvalid,
	input  wire logic          arready,
	output gfx::word           araddr,

	input  wire logic          rvalid,
	output logic               rready,
	input  wire gfx::word      rdata
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WRITE_ADDR_DATA,
		ST_WRITE_RESP,
		ST_READ_ADDR,
		ST_READ_DATA,
		ST_DONE
	} axil_state;

	axil_state state;
	logic aw_done, w_done;

	assign aw_done = ~awvalid | awready; // AW handshake finished by this edge.
	assign w_done = ~wvalid | wready;

	// Core holds these until req_ready.
	assign awaddr = req_addr;
	assign araddr = req_addr;
	assign wdata = req_wdata;
	assign wstrb = req_wstrb;

	assign bready = 1'b1;
	assign rready = 1'b1;
	assign req_ready = state == ST_DONE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			state <= ST_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_valid && |req_wstrb) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= ST_WRITE_ADDR_DATA;
					end else if (req_valid) begin
						arvalid <= 1'b1;
						state <= ST_READ_ADDR;
					end
				end

				ST_WRITE_ADDR_DATA: begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (aw_done && w_done)
						state <= ST_WRITE_RESP;
				end

				ST_WRITE_RESP:
					if (bvalid)
						state <= ST_DONE;

				ST_READ_ADDR:
					if (arready) begin
						arvalid <= 1'b0;
						state <= ST_READ_DATA;
					end

				ST_READ_DATA:
					if (rvalid)
						state <= ST_DONE;

				default: state <= ST_IDLE; // Done lasts one cycle.
			endcase
		end
	end

	always_ff @(posedge clk)
		if (state == ST_READ_DATA && rvalid)
			req_rdata <= rdata;

endmodule

`default_nettype wire

/* source/sched_mem_router.sv */
`default_nettype none

module sched_mem_router #(
	parameter int SCRATCH_WORDS = gfx::SCHED_BRAM_WORDS_DEFAULT
) (
	input  wire logic                               clk,
	input  wire logic                               rst_n,

	// Core look-ahead, one cycle ahead of mem_valid.
	input  wire logic                               la_read,
	input  wire logic                               la_write,
	input  wire gfx::word                           la_addr,

	input  wire logic                               mem_valid,
	input  wire gfx::word                           mem_addr,
	input  wire gfx::word_strb                      mem_wstrb,
	output logic                                    mem_ready,
	output gfx::word                                mem_rdata,

	// Scratchpad.
	output logic [$clog2(SCRATCH_WORDS) - 1:0]      ram_addr,
	output logic                                    ram_we,
	input  wire gfx::word                           ram_rdata,

	// AXI-lite master.
	output logic                                    req_valid,
	input  wire logic                               req_ready,
	input  wire gfx::word                           req_rdata
);

	import gfx::*;

	localparam int INDEX_BITS = $clog2(SCRATCH_WORDS);

	logic in_window;
	logic ram_rd_sel, ram_wr_sel, ram_ready;
	logic axi_sel;

	// Everything above the window goes out on AXI.
	assign in_window = ~|la_addr[$bits(word) - 1:INDEX_BITS + SUBWORD_BITS];

	assign ram_addr = mem_addr[INDEX_BITS + SUBWORD_BITS - 1:SUBWORD_BITS];
	assign ram_we = ram_wr_sel & mem_valid & (|mem_wstrb);

	assign req_valid = mem_valid & axi_sel;

	assign mem_ready = ram_ready | (axi_sel & req_ready);
	assign mem_rdata = ram_ready ? ram_rdata : req_rdata;

	// *******************************************************************
	// Target tracking.
	// *******************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			ram_rd_sel <= 1'b0;
			ram_wr_sel <= 1'b0;
			ram_ready <= 1'b0;
			axi_sel <= 1'b0;
		end else begin
			ram_rd_sel <= la_read & in_window;
			ram_wr_sel <= la_write & in_window;
			ram_ready <= ram_rd_sel | (la_write & in_window); // Writes answer a cycle early.
			axi_sel <= ((la_read | la_write) & ~in_window) | (axi_sel & ~req_ready);
		end
	end

endmodule

`default_nettype wire

/* source/gfx_sched_bus.sv */
`default_nettype none

module gfx_sched_bus #(
	parameter int SCRATCH_WORDS = gfx::SCHED_BRAM_WORDS_DEFAULT
) (
	input  wire logic          clk,
	input  wire logic          rst_n,

	// *******************************************************************
	// Core memory bus.
	// *******************************************************************

	input  wire logic          la_read,
	input  wire logic          la_write,
	input  wire gfx::word      la_addr,

	input  wire logic          mem_valid,
	input  wire gfx::word      mem_addr,
	input  wire gfx::word      mem_wdata,
	input  wire gfx::word_strb mem_wstrb,
	output logic               mem_ready,
	output gfx::word           mem_rdata,

	// *******************************************************************
	// AXI-lite master port.
	// *******************************************************************

	output logic               awvalid,
	input  wire logic          awready,
	output gfx::word           awaddr,

	output logic               wvalid,
	input  wire logic          wready,
	output gfx::word           wdata,
	output gfx::word_strb      wstrb,

	input  wire logic          bvalid,
	output logic               bready,

	output logic               arvalid,
	input  wire logic          arready,
	output gfx::word           araddr,

	input  wire logic          rvalid,
	output logic               rready,
	input  wire gfx::word      rdata
);

	import gfx::*;

	logic [$clog2(SCRATCH_WORDS) - 1:0] ram_addr;
	logic ram_we;
	word ram_rdata;

	logic req_valid, req_ready;
	word req_rdata;

	sched_mem_router #(
		.SCRATCH_WORDS(SCRATCH_WORDS)
	) router (
		.clk,
		.rst_n,
		.la_read,
		.la_write,
		.la_addr,
		.mem_valid,
		.mem_addr,
		.mem_wstrb,
		.mem_ready,
		.mem_rdata,
		.ram_addr,
		.ram_we,
		.ram_rdata,
		.req_valid,
		.req_ready,
		.req_rdata
	);

	sched_scratchpad #(
		.SCRATCH_WORDS(SCRATCH_WORDS)
	) scratchpad (
		.clk,
		.addr(ram_addr),
		.we(ram_we),
		.wstrb(mem_wstrb),
		.wdata(mem_wdata),
		.rdata(ram_rdata)
	);

	sched_axil_master axil (
		.clk,
		.rst_n,
		.req_valid,
		.req_addr(mem_addr),
		.req_wdata(mem_wdata),
		.req_wstrb(mem_wstrb), // Byte strobes reach W.
		.req_ready,
		.req_rdata,
		.awvalid,
		.awready,
		.awaddr,
		.wvalid,
		.wready,
		.wdata,
		.wstrb,
		.bvalid,
		.bready,
		.arvalid,
		.arready,
		.araddr,
		.rvalid,
		.rready,
		.rdata
	);

endmodule

`default_nettype wire

/* tests/axil_slave_model.sv */
`default_nettype none

module axil_slave_model (
	input  wire logic          clk,
	input  wire logic          rst_n,

	input  wire logic          awvalid,
	output logic               awready,
	input  wire gfx::word      awaddr,

	input  wire logic          wvalid,
	output logic               wready,
	input  wire gfx::word      wdata,
	input  wire gfx::word_strb wstrb,

	output logic               bvalid,
	input  wire logic          bready,

	input  wire logic          arvalid,
	output logic               arready,
	input  wire gfx::word      araddr,

	output logic               rvalid,
	input  wire logic          rready,
	output gfx::word           rdata,

	output int                 access_count
);

	import gfx::*;

	word mem [256]; // Indexed by address bits 9:2.
	int seed;
	word rnd;

	logic aw_got, w_got, ar_got;
	logic [7:0] wr_idx;
	logic [7:0] rd_idx;
	word wr_data;
	word_strb wr_strb;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seed = 7059;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			ar_got <= 1'b0;
			access_count <= 0;
		end else begin
			rnd = $random(seed);
			awready <= rnd[0] & ~aw_got; // Coin flip per cycle gives random delays.
			wready <= rnd[1] & ~w_got;
			arready <= rnd[2] & ~ar_got;

			// *************************************************************
			// Write path.
			// *************************************************************

			if (awvalid && awready && !aw_got) begin
				aw_got <= 1'b1;
				wr_idx <= awaddr[9:2];
			end
			if (wvalid && wready && !w_got) begin
				w_got <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if (aw_got && w_got && !bvalid && rnd[3]) begin
				for (int b = 0; b < BYTES_PER_WORD; b++)
					if (wr_strb[b])
						mem[wr_idx][8 * b +: 8] <= wr_data[8 * b +: 8];
				bvalid <= 1'b1;
				aw_got <= 1'b0;
				w_got <= 1'b0;
				access_count <= access_count + 1;
			end

			// *************************************************************
			// Read path.
			// *************************************************************

			if (arvalid && arready && !ar_got) begin
				ar_got <= 1'b1;
				rd_idx <= araddr[9:2];
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (ar_got && !rvalid && rnd[4]) begin
				rdata <= mem[rd_idx];
				rvalid <= 1'b1;
				ar_got <= 1'b0;
				access_count <= access_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_sched_bus.sv */
`default_nettype none

module tb_sched_bus;

	import gfx::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLE_BOUND = 64; // Per request.
	localparam int MAX_REQUESTS = 64; // Upper bound over all tests.
	localparam int SCRATCH_WORDS = SCHED_BRAM_WORDS_DEFAULT;
	localparam word AXI_BASE = 4 * SCRATCH_WORDS;

	logic clk;
	logic rst_n;
	logic la_read, la_write;
	word la_addr;
	logic mem_valid, mem_ready;
	word mem_addr, mem_wdata, mem_rdata;
	word_strb mem_wstrb;

	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	word awaddr, wdata, araddr, rdata;
	word_strb wstrb;
	int access_count;

	int seed;
	int errors;
	int checks;
	int requests;
	int ready_pulses;
	word shadow [word];

	gfx_sched_bus #(
		.SCRATCH_WORDS(SCRATCH_WORDS)
	) DUT (.*);

	axil_slave_model slave (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk)
		if (rst_n && mem_ready)
			ready_pulses++;

	// AXI addresses follow the open request.
	always @(negedge clk) begin
		if (awvalid)
			check(awaddr, mem_addr, "awaddr of the open request");
		if (arvalid)
			check(araddr, mem_addr, "araddr of the open request");
	end

	initial begin
		#((RESET_CYCLES + MAX_REQUESTS * CYCLE_BOUND) * CLK_PERIOD);
		$display("timeout: the bus stopped answering before the tests finished");
		$display("sim failed");
		$finish;
	end

	// *******************************************************************
	// Helpers.
	// *******************************************************************

	task automatic check(input word got, input word expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	function automatic word apply_strobes(input word old_word, input word new_word,
			input word_strb strb);
		word result;
		result = old_word;
		for (int b = 0; b < BYTES_PER_WORD; b++)
			if (strb[b])
				result[8 * b +: 8] = new_word[8 * b +: 8];
		return result;
	endfunction

	function automatic word model_word(input word addr);
		return slave.mem[addr[9:2]];
	endfunction

	// Look-ahead pulse, then hold the request until mem_ready.
	task automatic bus_access(input word addr, input word data, input word_strb strb,
			output word rd);
		@(negedge clk);
		la_read = ~|strb;
		la_write = |strb;
		la_addr = addr;
		@(negedge clk);
		la_read = 1'b0;
		la_write = 1'b0;
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = data;
		mem_wstrb = strb;
		while (!mem_ready)
			@(negedge clk);
		rd = mem_rdata;
		requests++;
		@(negedge clk); // Handshake edge has passed.
		mem_valid = 1'b0;
	endtask

	task automatic write_word(input word addr, input word data, input word_strb strb);
		word old_word;
		word unused_rd;
		old_word = shadow.exists(addr) ? shadow[addr] : '0;
		shadow[addr] = apply_strobes(old_word, data, strb);
		bus_access(addr, data, strb, unused_rd);
	endtask

	task automatic read_check(input word addr);
		word rd;
		bus_access(addr, '0, '0, rd);
		check(rd, shadow[addr], $sformatf("read of %h", addr));
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	// *******************************************************************
	// Tests.
	// *******************************************************************

	task automatic test_reset();
		int errors_before;
		errors_before = errors;
		rst_n = 1'b0;
		for (int cycle = 0; cycle < RESET_CYCLES + 3; cycle++) begin
			@(negedge clk);
			if (cycle == RESET_CYCLES)
				rst_n = 1'b1;
			check(word'(mem_ready), '0, "mem_ready around reset");
			check(word'(awvalid), '0, "awvalid around reset");
			check(word'(wvalid), '0, "wvalid around reset");
			check(word'(arvalid), '0, "arvalid around reset");
		end
		finish_test("reset", errors_before);
	endtask

	task automatic test_scratchpad();
		int errors_before;
		int count_before;
		word rd;
		errors_before = errors;
		count_before = access_count;
		write_word(32'h0000_0010, 32'h1122_3344, 4'b1111);
		read_check(32'h0000_0010);
		write_word(32'h0000_0010, 32'hAABB_CCDD, 4'b0101);
		bus_access(32'h0000_0010, '0, '0, rd);
		check(rd, 32'h11BB_33DD, "partial strobe merge");
		write_word(32'h0000_0010, 32'h5500_0000, 4'b1000);
		read_check(32'h0000_0010);
		write_word(32'h0000_0200, 32'hDEAD_BEEF, 4'b1111);
		read_check(32'h0000_0200);
		read_check(32'h0000_0010);
		check(access_count, count_before, "scratchpad traffic reached AXI");
		finish_test("scratchpad", errors_before);
	endtask

	task automatic test_axi();
		int errors_before;
		int count_before;
		word addr;
		errors_before = errors;
		count_before = access_count;
		addr = AXI_BASE + 32'h40;
		write_word(addr, 32'hCAFE_F00D, 4'b1111);
		check(model_word(addr), 32'hCAFE_F00D, "AXI write data");
		write_word(addr, 32'h0012_3400, 4'b0110);
		check(model_word(addr), 32'hCA12_340D, "AXI write strobes");
		read_check(addr);
		check(access_count, count_before + 3, "AXI access count");
		check(word'(bready), 32'd1, "bready held high");
		check(word'(rready), 32'd1, "rready held high");
		finish_test("axi", errors_before);
	endtask

	task automatic test_boundary();
		int errors_before;
		int count_before;
		errors_before = errors;
		count_before = access_count;
		write_word(AXI_BASE - 4, 32'h0BAD_CAFE, 4'b1111);
		read_check(AXI_BASE - 4);
		check(access_count, count_before, "last scratchpad word left the window");
		write_word(AXI_BASE, 32'h600D_F00D, 4'b1111);
		read_check(AXI_BASE);
		check(access_count, count_before + 2, "first word past the window stayed local");
		check(model_word(AXI_BASE), 32'h600D_F00D, "first word past the window in model");
		finish_test("boundary", errors_before);
	endtask

	task automatic test_backpressure();
		int errors_before;
		int pick;
		word addrs [16];
		word rnd;
		word_strb strb;
		errors_before = errors;
		for (int i = 0; i < 16; i++)
			addrs[i] = (i % 2 == 0) ? 32'h100 + 4 * i : AXI_BASE + 32'h100 + 4 * i;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			write_word(addrs[i], rnd, 4'b1111);
		end
		repeat (8) begin
			rnd = $random(seed);
			strb = rnd[3:0];
			if (strb == '0)
				strb = 4'b1001;
			pick = int'(rnd[7:4]);
			rnd = $random(seed);
			write_word(addrs[pick], rnd, strb);
		end
		for (int i = 15; i >= 0; i--)
			read_check(addrs[i]);
		check(ready_pulses, requests, "mem_ready pulses per request");
		finish_test("backpressure", errors_before);
	endtask

	initial begin
		seed = 7059;
		errors = 0;
		checks = 0;
		requests = 0;
		rst_n = 1'b0;
		la_read = 1'b0;
		la_write = 1'b0;
		la_addr = '0;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;

		test_reset();
		test_scratchpad();
		test_axi();
		test_boundary();
		test_backpressure();

		$display("%0d checks, %0d errors, %0d requests", checks, errors, requests);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* gfx_sched_bus.f */
source/gfx_pkg.sv
source/sched_scratchpad.sv
source/sched_axil_master.sv
source/sched_mem_router.sv
source/gfx_sched_bus.sv
tests/axil_slave_model.sv
tests/tb_sched_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
	--top-module tb_sched_bus \
	-Mdir "$BUILD_DIR" \
	-o tb_sched_bus \
	-f gfx_sched_bus.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_sched_bus" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
